/* lsu_subsys.f */
+incdir+.
lsu_pkg.sv
lsu_load_align.sv
lsu_store_mask.sv
lsu_ctrl_fsm.sv
mem_wait_timer.sv
lsu_data_mem.sv
lsu_top.sv
tb_lsu_top.sv

/* tb_lsu_top.sv */
// lsu testbench: drives loads and stores and checks against a reference memory model
`timescale 1ns/10ps
`default_nettype none

`include "lsu_cfg.svh"

module tb_lsu_top import lsu_pkg::*; ();

  localparam int    IDX_W     = $clog2(`LSU_MEM_WORDS);
  localparam addr_t MEM_BYTES = `LSU_MEM_WORDS * 8;

  logic      clk = 1'b0;
  logic      rst, st_req, ld_req, busy, st_done, st_err, ld_err, wen_reg;
  addr_t     addr;
  xdata_t    st_data, wdata_reg;
  st_width_t st_width;
  ld_width_t ld_width;
  regidx_t   rd, waddr_reg;

  xdata_t  ref_mem [`LSU_MEM_WORDS];
  integer  seed;
  int      st_cnt = 0;
  int      ld_cnt = 0;
  logic    got_err;
  xdata_t  got_data;
  regidx_t got_rd;

  always #5 clk = ~clk;

  lsu_top dut0 (
    .clk (clk), .rst (rst), .st_req_i (st_req), .ld_req_i (ld_req), .addr_i (addr),
    .st_data_i (st_data), .st_width_i (st_width), .ld_width_i (ld_width), .rd_i (rd),
    .busy_o (busy), .st_done_o (st_done), .st_err_o (st_err), .ld_err_o (ld_err),
    .wen_reg_o (wen_reg), .waddr_reg_o (waddr_reg), .wdata_reg_o (wdata_reg)
  );

  // strobe counters sampled mid-cycle
  always @(negedge clk) begin
    if (st_done) st_cnt++;
    if (wen_reg) ld_cnt++;
  end

  // ============================================================
  // reference model
  // ============================================================
  function automatic xdata_t ref_load(input xdata_t w, input ld_width_t k);
    case (k)
      6'b100000: ref_load = $signed(w[31:0]);
      6'b010000: ref_load = $signed(w[15:0]);
      6'b001000: ref_load = $signed(w[7:0]);
      6'b000100: ref_load = w[31:0];
      6'b000010: ref_load = w[15:0];
      6'b000001: ref_load = w[7:0];
      default:   ref_load = w;
    endcase
  endfunction

  task automatic ref_write(input addr_t a, input xdata_t d, input st_width_t k);
    int nbytes;
    nbytes = (k == 4'b0100) ? 1 : (k == 4'b0010) ? 2 : (k == 4'b0001) ? 4 : 8;
    if (a < MEM_BYTES) begin
      for (int b = 0; b < nbytes; b++) ref_mem[a[3 +: IDX_W]][b*8 +: 8] = d[b*8 +: 8];
    end
  endtask

  // ============================================================
  // checks and bus tasks
  // ============================================================
  task automatic check_val(input string name, input xdata_t exp, input xdata_t act);
    if (act !== exp) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      $display("Test failures found");
      $fatal(1, "mismatch");
    end
  endtask

  // wait for the finishing strobe, capture the results, return just after the next edge
  task automatic wait_end(input logic is_load);
    int t;
    t = 0;
    @(negedge clk);
    while (!(is_load ? wen_reg : st_done)) begin
      t++;
      if (t > 200) begin
        $display("Timeout: the DUT never finished the %s", is_load ? "load" : "store");
        $display("Test failures found");
        $fatal(1, "timeout");
      end
      @(negedge clk);
    end
    got_err  = is_load ? ld_err : st_err;
    got_data = wdata_reg;
    got_rd   = waddr_reg;
    @(posedge clk);
    #1;
  endtask

  task automatic do_store(input addr_t a, input xdata_t d, input st_width_t k, input string name);
    addr = a;
    st_data = d;
    st_width = k;
    st_req = 1'b1;
    @(posedge clk);
    #1;
    st_req = 1'b0;
    wait_end(1'b0);
    check_val({name, " st_err"}, a >= MEM_BYTES, got_err);
    ref_write(a, d, k);
  endtask

  task automatic do_load(input addr_t a, input ld_width_t k, input regidx_t r, input string name);
    logic bad;
    bad = (a >= MEM_BYTES);
    addr = a;
    ld_width = k;
    rd = r;
    ld_req = 1'b1;
    @(posedge clk);
    #1;
    ld_req = 1'b0;
    wait_end(1'b1);
    check_val({name, " ld_err"}, bad, got_err);
    check_val({name, " rd"}, r, got_rd);
    check_val({name, " data"}, bad ? '0 : ref_load(ref_mem[a[3 +: IDX_W]], k), got_data);
  endtask

  // ============================================================
  // test sequence
  // ============================================================
  initial begin
    int     base_st, base_ld;
    xdata_t w, d1;
    addr_t  a;
    seed = 32'h7a9a_4281;
    rst = 1'b1;
    st_req = 1'b0;
    ld_req = 1'b0;
    addr = '0;
    st_data = '0;
    st_width = '0;
    ld_width = '0;
    rd = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    check_val("reset outputs", '0, {busy, st_done, wen_reg, st_err, ld_err});

    // memory model has no reset, so clear every word first
    for (int i = 0; i < `LSU_MEM_WORDS; i++) do_store(i * 8, '0, 4'b1000, "init");

    // sd then ld
    do_store(64'h40, {$random(seed), $random(seed)}, 4'b1000, "sd basic");
    do_load(64'h40, 6'b0, 5'd13, "ld basic");

    // narrow stores touch only the low bytes
    do_store(64'h80, {$random(seed), $random(seed)}, 4'b1000, "sd base");
    for (int k = 0; k < 3; k++) begin
      do_store(64'h80, {$random(seed), $random(seed)}, 4'b0100 >> k, "narrow st");
      do_load(64'h80, 6'b0, 5'd7, "narrow st ld");
    end

    // six narrow load kinds with the top selected bits forced high or low
    for (int j = 0; j < 4; j++) begin
      w = {$random(seed), $random(seed)};
      w = j[0] ? (w | 64'h8000_8080) : (w & ~64'h8000_8080);
      do_store(64'hc0 + j * 8, w, 4'b1000, "ext sd");
      for (int k = 0; k < 6; k++) do_load(64'hc0 + j * 8, 6'b1 << k, 5'(j + k), "ext ld");
    end

    // out of range gives error strobes and zero data and leaves the aliased word alone
    do_store(MEM_BYTES, {$random(seed), $random(seed)}, 4'b1000, "oor sd");
    do_load(MEM_BYTES, 6'b0, 5'd3, "oor ld");
    do_load(64'hffff_0000_0000_0008, 6'b100000, 5'd4, "oor lw");
    do_load(64'h0, 6'b0, 5'd5, "alias ld");

    // requests during busy are dropped
    base_st = st_cnt;
    base_ld = ld_cnt;
    d1 = {$random(seed), $random(seed)};
    addr = 64'h100;
    st_data = d1;
    st_width = 4'b1000;
    st_req = 1'b1;
    @(posedge clk);
    #1;
    check_val("busy after accept", 1'b1, busy);
    // second store strobe while busy
    addr = 64'h108;
    st_data = ~d1;
    @(posedge clk);
    #1;
    // lone load strobe while busy
    st_req = 1'b0;
    ld_req = 1'b1;
    @(posedge clk);
    #1;
    ld_req = 1'b0;
    wait_end(1'b0);
    repeat (20) @(posedge clk);
    #1;
    check_val("busy st count", 1, st_cnt - base_st);
    check_val("busy ld count", 0, ld_cnt - base_ld);
    ref_write(64'h100, d1, 4'b1000);
    do_load(64'h100, 6'b0, 5'd9, "busy first");
    do_load(64'h108, 6'b0, 5'd10, "busy second");

    // mixed random traffic
    for (int i = 0; i < 40; i++) begin
      a = ($random(seed) & 8'hff) * 8;
      if ($random(seed) & 1) begin
        do_store(a, {$random(seed), $random(seed)}, 4'b1 << ($random(seed) & 3), "rand st");
      end else begin
        w = ($random(seed) & 7) % 7;
        do_load(a, (w == 6) ? 6'b0 : 6'b1 << w, 5'($random(seed)), "rand ld");
      end
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

/* lsu_top.sv */
// lsu top: load/store unit with store formatting, load alignment and memory model
`timescale 1ns/10ps
`default_nettype none

module lsu_top import lsu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      st_req_i,
  input  logic      ld_req_i,
  input  addr_t     addr_i,
  input  xdata_t    st_data_i,
  input  st_width_t st_width_i,
  input  ld_width_t ld_width_i,
  input  regidx_t   rd_i,
  output logic      busy_o,
  output logic      st_done_o,
  output logic      st_err_o,
  output logic      ld_err_o,
  output logic      wen_reg_o,
  output regidx_t   waddr_reg_o,
  output xdata_t    wdata_reg_o
);

  // formatted store payload
  strb_t     st_strb;
  xdata_t    st_wdata;
  ld_width_t ld_width;

  // write bus
  logic   aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  addr_t  aw_addr;
  xdata_t w_data;
  strb_t  w_strb;
  resp_t  b_resp;

  // read bus
  logic   ar_valid, ar_ready, r_valid, r_ready;
  addr_t  ar_addr;
  xdata_t r_data;
  resp_t  r_resp;

  lsu_store_mask u_store_mask (
    .st_width_i (st_width_i),
    .st_data_i  (st_data_i),
    .st_strb_o  (st_strb),
    .st_wdata_o (st_wdata)
  );

  lsu_ctrl_fsm u_ctrl (
    .clk (clk), .rst (rst),
    .st_req_i (st_req_i), .ld_req_i (ld_req_i), .addr_i (addr_i), .rd_i (rd_i),
    .ld_width_i (ld_width_i), .st_wdata_i (st_wdata), .st_strb_i (st_strb),
    .aw_ready_i (aw_ready), .w_ready_i (w_ready), .b_valid_i (b_valid),
    .b_resp_i (b_resp), .ar_ready_i (ar_ready), .r_valid_i (r_valid), .r_resp_i (r_resp),
    .aw_valid_o (aw_valid), .aw_addr_o (aw_addr), .w_valid_o (w_valid),
    .w_data_o (w_data), .w_strb_o (w_strb), .b_ready_o (b_ready),
    .ar_valid_o (ar_valid), .ar_addr_o (ar_addr), .r_ready_o (r_ready),
    .ld_width_o (ld_width), .busy_o (busy_o), .st_done_o (st_done_o),
    .st_err_o (st_err_o), .ld_err_o (ld_err_o), .wen_reg_o (wen_reg_o),
    .waddr_reg_o (waddr_reg_o)
  );

  lsu_load_align u_load_align (
    .ld_width_i (ld_width),
    .r_data_i   (r_data),
    .ld_data_o  (wdata_reg_o)
  );

  lsu_data_mem u_mem (
    .clk (clk), .rst (rst),
    .aw_valid_i (aw_valid), .aw_addr_i (aw_addr), .w_valid_i (w_valid),
    .w_data_i (w_data), .w_strb_i (w_strb), .b_ready_i (b_ready),
    .ar_valid_i (ar_valid), .ar_addr_i (ar_addr), .r_ready_i (r_ready),
    .aw_ready_o (aw_ready), .w_ready_o (w_ready), .b_valid_o (b_valid),
    .b_resp_o (b_resp), .ar_ready_o (ar_ready), .r_valid_o (r_valid),
    .r_data_o (r_data), .r_resp_o (r_resp)
  );

endmodule

`default_nettype wire

/* lsu_data_mem.sv */
// data memory model: bus slave with wait cycles, byte-masked writes and range errors
`timescale 1ns/10ps
`default_nettype none

`include "lsu_cfg.svh"

module lsu_data_mem import lsu_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   aw_valid_i,
  input  addr_t  aw_addr_i,
  input  logic   w_valid_i,
  input  xdata_t w_data_i,
  input  strb_t  w_strb_i,
  input  logic   b_ready_i,
  input  logic   ar_valid_i,
  input  addr_t  ar_addr_i,
  input  logic   r_ready_i,
  output logic   aw_ready_o,
  output logic   w_ready_o,
  output logic   b_valid_o,
  output resp_t  b_resp_o,
  output logic   ar_ready_o,
  output logic   r_valid_o,
  output xdata_t r_data_o,
  output resp_t  r_resp_o
);

  localparam int unsigned IDX_W     = $clog2(`LSU_MEM_WORDS);
  localparam addr_t       MEM_BYTES = addr_t'(`LSU_MEM_WORDS) << 3;

  xdata_t mem_q [`LSU_MEM_WORDS];

  addr_t wr_addr_q, rd_addr_q;
  logic  wr_pend_q, rd_pend_q;
  logic  idle, tmr_done, aw_hs, ar_hs, w_hs, wr_ok, rd_ok;

  // ============================================================
  // handshakes and wait timer
  // ============================================================
  assign idle       = !wr_pend_q && !rd_pend_q && !b_valid_o;
  assign aw_ready_o = idle;
  assign ar_ready_o = idle;
  assign aw_hs      = aw_valid_i && aw_ready_o;
  assign ar_hs      = ar_valid_i && ar_ready_o;
  assign w_hs       = w_valid_i && w_ready_o;

  mem_wait_timer u_timer (
    .clk     (clk),
    .rst     (rst),
    .start_i (aw_hs || ar_hs),
    .done_o  (tmr_done)
  );

  assign wr_ok = (wr_addr_q < MEM_BYTES);
  assign rd_ok = (rd_addr_q < MEM_BYTES);

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_pend_q <= 1'b0;
      rd_pend_q <= 1'b0;
      b_valid_o <= 1'b0;
      b_resp_o  <= RESP_OKAY;
    end else begin
      if (aw_hs) wr_pend_q <= 1'b1;
      else if (w_hs) wr_pend_q <= 1'b0;
      if (ar_hs) rd_pend_q <= 1'b1;
      else if (r_valid_o && r_ready_i) rd_pend_q <= 1'b0;
      // one response per write
      if (w_hs) begin
        b_valid_o <= 1'b1;
        b_resp_o  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
      end else if (b_ready_i) begin
        b_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) wr_addr_q <= aw_addr_i;
    if (ar_hs) rd_addr_q <= ar_addr_i;
  end

  // ============================================================
  // storage
  // ============================================================
  always_ff @(posedge clk) begin
    if (w_hs && wr_ok) begin
      for (int b = 0; b < 8; b++) begin
        if (w_strb_i[b]) mem_q[wr_addr_q[3 +: IDX_W]][b*8 +: 8] <= w_data_i[b*8 +: 8];
      end
    end
  end

  assign w_ready_o = wr_pend_q && tmr_done;
  assign r_valid_o = rd_pend_q && tmr_done;
  // data and response read as zero outside the answer cycle
  assign r_data_o  = (r_valid_o && rd_ok) ? mem_q[rd_addr_q[3 +: IDX_W]] : '0;
  assign r_resp_o  = (r_valid_o && !rd_ok) ? RESP_SLVERR : RESP_OKAY;

endmodule

`default_nettype wire

/* mem_wait_timer.sv */
// memory wait timer: down-counter that holds off the memory answer
`timescale 1ns/10ps
`default_nettype none

`include "lsu_cfg.svh"

module mem_wait_timer (
  input  logic clk,
  input  logic rst,
  input  logic start_i,
  output logic done_o
);

  localparam int unsigned WAIT  = `LSU_WAIT_CYCLES;
  localparam int unsigned CNT_W = (WAIT > 0) ? $clog2(WAIT + 1) : 1;

  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= CNT_W'(WAIT);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign done_o = (cnt_q == '0) && !start_i;

endmodule

`default_nettype wire

/* lsu_ctrl_fsm.sv */
// lsu control: write and read channel FSMs, request capture, done and write-back strobes
`timescale 1ns/10ps
`default_nettype none

module lsu_ctrl_fsm import lsu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      st_req_i,
  input  logic      ld_req_i,
  input  addr_t     addr_i,
  input  regidx_t   rd_i,
  input  ld_width_t ld_width_i,
  input  xdata_t    st_wdata_i,
  input  strb_t     st_strb_i,
  input  logic      aw_ready_i,
  input  logic      w_ready_i,
  input  logic      b_valid_i,
  input  resp_t     b_resp_i,
  input  logic      ar_ready_i,
  input  logic      r_valid_i,
  input  resp_t     r_resp_i,
  output logic      aw_valid_o,
  output addr_t     aw_addr_o,
  output logic      w_valid_o,
  output xdata_t    w_data_o,
  output strb_t     w_strb_o,
  output logic      b_ready_o,
  output logic      ar_valid_o,
  output addr_t     ar_addr_o,
  output logic      r_ready_o,
  output ld_width_t ld_width_o,
  output logic      busy_o,
  output logic      st_done_o,
  output logic      st_err_o,
  output logic      ld_err_o,
  output logic      wen_reg_o,
  output regidx_t   waddr_reg_o
);

  wr_state_t wr_state, wr_next;
  rd_state_t rd_state, rd_next;

  addr_t     addr_q;
  xdata_t    w_data_q;
  strb_t     w_strb_q;
  regidx_t   rd_q;
  ld_width_t ld_width_q;

  logic st_acc;
  logic ld_acc;

  // ============================================================
  // request acceptance
  // ============================================================
  assign busy_o = (wr_state != WR_IDLE) || (rd_state != RD_IDLE);
  // store wins a tie
  assign st_acc = st_req_i && !busy_o;
  assign ld_acc = ld_req_i && !st_req_i && !busy_o;

  always_ff @(posedge clk) begin
    if (st_acc) begin
      addr_q   <= addr_i;
      w_data_q <= st_wdata_i;
      w_strb_q <= st_strb_i;
    end else if (ld_acc) begin
      addr_q     <= addr_i;
      rd_q       <= rd_i;
      ld_width_q <= ld_width_i;
    end
  end

  // ============================================================
  // write channel
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state <= WR_IDLE;
    end else begin
      wr_state <= wr_next;
    end
  end

  always_comb begin
    wr_next = wr_state;
    case (wr_state)
      WR_IDLE: if (st_acc) wr_next = WR_ADDR;
      WR_ADDR: if (aw_ready_i) wr_next = WR_DATA;
      WR_DATA: if (w_ready_i) wr_next = WR_RESP;
      WR_RESP: if (b_valid_i) wr_next = WR_IDLE;
      default: wr_next = WR_IDLE;
    endcase
  end

  assign aw_valid_o = (wr_state == WR_ADDR);
  assign aw_addr_o  = addr_q;
  assign w_valid_o  = (wr_state == WR_DATA);
  assign w_data_o   = w_data_q;
  assign w_strb_o   = w_strb_q;
  assign b_ready_o  = (wr_state == WR_RESP);

  assign st_done_o = b_ready_o && b_valid_i;
  assign st_err_o  = st_done_o && (b_resp_i != RESP_OKAY);

  // ============================================================
  // read channel
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= RD_IDLE;
    end else begin
      rd_state <= rd_next;
    end
  end

  always_comb begin
    rd_next = rd_state;
    case (rd_state)
      RD_IDLE: if (ld_acc) rd_next = RD_ADDR;
      RD_ADDR: if (ar_ready_i) rd_next = RD_DATA;
      RD_DATA: if (r_valid_i) rd_next = RD_IDLE;
      default: rd_next = RD_IDLE;
    endcase
  end

  assign ar_valid_o = (rd_state == RD_ADDR);
  assign ar_addr_o  = addr_q;
  assign r_ready_o  = (rd_state == RD_DATA);
  assign ld_width_o = ld_width_q;

  // write-back on the R transfer
  assign wen_reg_o   = r_ready_o && r_valid_i;
  assign waddr_reg_o = wen_reg_o ? rd_q : '0;
  assign ld_err_o    = wen_reg_o && (r_resp_i != RESP_OKAY);

endmodule

`default_nettype wire

/* lsu_store_mask.sv */
// store mask: byte mask and clean low-lane write data from the store kind
`timescale 1ns/10ps
`default_nettype none

module lsu_store_mask import lsu_pkg::*; (
  input  st_width_t st_width_i,
  input  xdata_t    st_data_i,
  output strb_t     st_strb_o,
  output xdata_t    st_wdata_o
);

  always_comb begin
    case (st_width_i)
      4'b1000: st_strb_o = 8'b1111_1111;
      4'b0100: st_strb_o = 8'b0000_0001;
      4'b0010: st_strb_o = 8'b0000_0011;
      4'b0001: st_strb_o = 8'b0000_1111;
      default: st_strb_o = 8'b1111_1111;
    endcase
  end

  // clear bytes outside the mask
  always_comb begin
    for (int b = 0; b < 8; b++) begin
      st_wdata_o[b*8 +: 8] = st_strb_o[b] ? st_data_i[b*8 +: 8] : 8'h00;
    end
  end

endmodule

`default_nettype wire

/* lsu_load_align.sv */
// load align: picks the low bytes of the read word and sign or zero extends them
`timescale 1ns/10ps
`default_nettype none

module lsu_load_align import lsu_pkg::*; (
  input  ld_width_t ld_width_i,
  input  xdata_t    r_data_i,
  output xdata_t    ld_data_o
);

  always_comb begin
    case (ld_width_i)
      // signed kinds
      6'b100000: begin
        ld_data_o = {{32{r_data_i[31]}}, r_data_i[31:0]};
      end
      6'b010000: begin
        ld_data_o = {{48{r_data_i[15]}}, r_data_i[15:0]};
      end
      6'b001000: begin
        ld_data_o = {{56{r_data_i[7]}}, r_data_i[7:0]};
      end
      // unsigned kinds
      6'b000100: begin
        ld_data_o = {32'b0, r_data_i[31:0]};
      end
      6'b000010: begin
        ld_data_o = {48'b0, r_data_i[15:0]};
      end
      6'b000001: begin
        ld_data_o = {56'b0, r_data_i[7:0]};
      end
      // ld, whole word
      default: begin
        ld_data_o = r_data_i;
      end
    endcase
  end

endmodule

`default_nettype wire

/* lsu_pkg.sv */
// lsu package: data, address, mask and width types plus channel FSM states
`default_nettype none

`include "lsu_cfg.svh"

package lsu_pkg;

  typedef logic [`LSU_XLEN-1:0] xdata_t;
  typedef logic [`LSU_AW-1:0]   addr_t;
  typedef logic [7:0]           strb_t;
  typedef logic [4:0]           regidx_t;

  // one-hot, high to low: lw lh lb lwu lhu lbu, all zero is ld
  typedef logic [5:0] ld_width_t;
  // one-hot, high to low: sd sb sh sw, all zero is full word
  typedef logic [3:0] st_width_t;

  typedef logic [1:0] resp_t;
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} wr_state_t;
  typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_t;

endpackage

`default_nettype wire

/* lsu_cfg.svh */
// lsu configuration: bus widths, memory depth and memory wait cycles
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// data word width in bits
`define LSU_XLEN 64

// byte address width in bits
`define LSU_AW 64

// memory model depth in 64-bit words
`define LSU_MEM_WORDS 256

// wait cycles between an address transfer and the memory answer
`define LSU_WAIT_CYCLES 2

`endif
